// File: mvsPkg.sv
package mvsPkg;

	// 23-bit word address, byte address bits 23..1
	typedef union packed {
		logic [22:0] word;
		// Zone view used by the decoder
		struct packed {
			logic [3:0]  zone;
			logic [18:0] offset;
		} zoneView;
		// I/O view used by the register stage
		struct packed {
			logic [3:0]  zone;
			logic [12:0] middle;
			logic [2:0]  group;
			logic [2:0]  index;
		} ioView;
	} mvsAddrT;

	// Raw zone field values, byte address bits 23..20
	localparam logic [3:0] FIELD_CART    = 4'h0;
	localparam logic [3:0] FIELD_IO      = 4'h3;
	localparam logic [3:0] FIELD_MEMCARD = 4'h8;
	localparam logic [3:0] FIELD_BIOS    = 4'hC;

	// Sub-block inside the I/O field, byte address bits 19..16
	// 0x30..0x39 control, 0x3A system latches
	localparam logic [3:0] IO_CTRL_TOP = 4'h9;
	localparam logic [3:0] IO_SYS_SUB  = 4'hA;

	// Decoded zone codes carried with a request
	localparam logic [3:0] ZONE_NONE     = 4'd0;
	localparam logic [3:0] ZONE_CART_ROM = 4'd1;
	localparam logic [3:0] ZONE_IO_CTRL  = 4'd2;
	localparam logic [3:0] ZONE_IO_SYS   = 4'd3;
	localparam logic [3:0] ZONE_MEMCARD  = 4'd4;
	localparam logic [3:0] ZONE_BIOS_ROM = 4'd5;

	// Read word offsets in the control zone
	// Only offset bits 18..17 are decoded, the rest mirror
	localparam logic [18:0] REG_P1CNT    = 19'h00000;
	localparam logic [18:0] REG_P2CNT    = 19'h20000;
	localparam logic [18:0] REG_STATUS_B = 19'h40000;

	// Write groups in the 0x38xxxx region, byte address bits 6..4
	localparam logic [2:0] GRP_POUTPUT  = 3'd0;
	localparam logic [2:0] GRP_LEDLATCH = 3'd1;
	localparam logic [2:0] GRP_SLOT     = 3'd2;
	localparam logic [2:0] GRP_LEDDATA  = 3'd3;
	localparam logic [2:0] GRP_COIN     = 3'd6;

	// System latch indices, byte address bits 3..1
	localparam logic [2:0] SYS_VEC      = 3'd0;
	localparam logic [2:0] SYS_SHADOW   = 3'd1;
	localparam logic [2:0] SYS_PALBANK  = 3'd2;
	localparam logic [2:0] SYS_SRAMLOCK = 3'd3;
	localparam logic [2:0] SYS_SYSTEM   = 3'd4;

	// Vector table window, in words
	localparam logic [6:0] VEC_SWAP_LIMIT = 7'd64;

	// Request-to-ack latency in clocks
	localparam logic [2:0] WAIT_FAST    = 3'd2;
	localparam logic [2:0] WAIT_MEMCARD = 3'd4;

	// Coin counter pulse width
	localparam logic [3:0] COIN_PULSE_CYCLES = 4'd8;

	// Open bus reads
	localparam logic [15:0] UNMAPPED_DATA = 16'hFFFF;

endpackage

// File: mvsCoinCtrl.sv
module mvsCoinCtrl (
	input  logic       clk24m,
	input  logic       rst,
	input  logic       coinWr,
	input  logic [1:0] coinSel,
	input  logic       coinVal,
	output logic [1:0] coinCnt,
	output logic [1:0] lockout
);

	// Remaining pulse length per counter
	logic [3:0] pulseLeft [2];

	// Counter pulses
	always_ff @(posedge clk24m) begin
		if (rst) begin
			pulseLeft[0] <= 4'd0;
			pulseLeft[1] <= 4'd0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// Selector 0/1 written with one, restarts if running
				if (coinWr && (coinSel == 2'(i)) && coinVal) begin
					pulseLeft[i] <= mvsPkg::COIN_PULSE_CYCLES;
				end else if (pulseLeft[i] != 4'd0) begin
					pulseLeft[i] <= pulseLeft[i] - 4'd1;
				end
			end
		end
	end

	// Lockout levels on selectors 2/3
	always_ff @(posedge clk24m) begin
		if (rst) begin
			lockout <= 2'b00;
		end else if (coinWr && coinSel[1]) begin
			lockout[coinSel[0]] <= coinVal;
		end
	end

	// Counter output high while the pulse runs
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			coinCnt[i] = (pulseLeft[i] != 4'd0);
		end
	end

endmodule

// File: mvsAddrDecode.sv
module mvsAddrDecode (
	input  logic            clk24m,
	input  logic            rst,
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  mvsPkg::mvsAddrT adr,
	input  logic [15:0]     datW,
	input  logic [1:0]      sel,
	input  logic            vecSwap,
	input  logic            done,
	output logic            reqValid,
	output logic            reqWe,
	output mvsPkg::mvsAddrT reqAddr,
	output logic [15:0]     reqDat,
	output logic [3:0]      reqZone,
	output logic            cartCs,
	output logic            biosCs,
	output logic            cardCs
);

	logic            busy;
	logic            capture;
	mvsPkg::mvsAddrT swapped;
	logic [3:0]      zoneCode;

	// New request only when idle, any byte lane counts
	assign capture = !busy && cyc && stb && (|sel);

	// Vector swap, low words land in BIOS like NEO-E0 does
	always_comb begin
		swapped = adr;
		if (vecSwap && (adr.word < 23'(mvsPkg::VEC_SWAP_LIMIT))) begin
			// Top two bits forced high, 0x0000xx becomes 0xC000xx
			swapped.word[22:21] = 2'b11;
		end
	end

	// Zone decode on the swapped address
	always_comb begin
		zoneCode = mvsPkg::ZONE_NONE;
		case (swapped.zoneView.zone)
			mvsPkg::FIELD_CART:    zoneCode = mvsPkg::ZONE_CART_ROM;
			mvsPkg::FIELD_MEMCARD: zoneCode = mvsPkg::ZONE_MEMCARD;
			mvsPkg::FIELD_BIOS:    zoneCode = mvsPkg::ZONE_BIOS_ROM;
			mvsPkg::FIELD_IO: begin
				// Split 0x30..0x39 from 0x3A, rest of 0x3x is open
				if (swapped.zoneView.offset[18:15] <= mvsPkg::IO_CTRL_TOP) begin
					zoneCode = mvsPkg::ZONE_IO_CTRL;
				end else if (swapped.zoneView.offset[18:15] == mvsPkg::IO_SYS_SUB) begin
					zoneCode = mvsPkg::ZONE_IO_SYS;
				end
			end
			default: zoneCode = mvsPkg::ZONE_NONE;
		endcase
	end

	// Control state
	always_ff @(posedge clk24m) begin
		if (rst) begin
			busy     <= 1'b0;
			reqValid <= 1'b0;
		end else begin
			reqValid <= capture;
			if (capture) begin
				busy <= 1'b1;
			end else if (done) begin
				busy <= 1'b0;
			end
		end
	end

	// Request payload, held until the next capture
	always_ff @(posedge clk24m) begin
		if (capture) begin
			reqWe   <= we;
			reqAddr <= swapped;
			reqDat  <= datW;
			reqZone <= zoneCode;
		end
	end

	// Chip selects one cycle after the request, dropped on done
	always_ff @(posedge clk24m) begin
		if (rst || done) begin
			cartCs <= 1'b0;
			biosCs <= 1'b0;
			cardCs <= 1'b0;
		end else if (reqValid) begin
			cartCs <= (reqZone == mvsPkg::ZONE_CART_ROM);
			biosCs <= (reqZone == mvsPkg::ZONE_BIOS_ROM);
			cardCs <= (reqZone == mvsPkg::ZONE_MEMCARD);
		end
	end

endmodule

// File: mvsIoRegs.sv
module mvsIoRegs (
	input  logic            clk24m,
	input  logic            rst,
	input  logic            reqValid,
	input  logic            reqWe,
	input  mvsPkg::mvsAddrT reqAddr,
	input  logic [15:0]     reqDat,
	input  logic [3:0]      reqZone,
	input  logic [7:0]      dipSw,
	input  logic [9:0]      p1In,
	input  logic [9:0]      p2In,
	output logic [15:0]     regDat,
	output logic [2:0]      p1Out,
	output logic [2:0]      p2Out,
	output logic [7:0]      ledOut1,
	output logic [7:0]      ledOut2,
	output logic [2:0]      slot,
	output logic            vecSwap,
	output logic            shadow,
	output logic            palBank,
	output logic            sramLock,
	output logic            system,
	output logic [1:0]      coinCnt,
	output logic [1:0]      lockout
);

	logic [1:0]  region;
	logic        ctrlWr;
	logic        sysWr;
	logic        sysVal;
	logic [7:0]  ledHold;
	logic [15:0] readWord;
	logic        coinWr;
	logic [1:0]  coinSel;
	logic        coinVal;

	// Byte address bits 19..18 pick the register block
	assign region = reqAddr.ioView.middle[12:11];

	// Writes only land in the 0x38/0x39 block
	assign ctrlWr = reqValid && reqWe && (reqZone == mvsPkg::ZONE_IO_CTRL)
		&& (region == mvsPkg::REG_STATUS_B[18:17]);
	assign sysWr = reqValid && reqWe && (reqZone == mvsPkg::ZONE_IO_SYS);

	// Latch value rides on byte address bit 4
	assign sysVal = reqAddr.ioView.group[0];

	// Coin block takes selector from byte address bits 2..1
	assign coinWr  = ctrlWr && (reqAddr.ioView.group == mvsPkg::GRP_COIN);
	assign coinSel = reqAddr.ioView.index[1:0];
	assign coinVal = reqDat[0];

	// Read word
	always_comb begin
		readWord = mvsPkg::UNMAPPED_DATA;
		if (reqZone == mvsPkg::ZONE_IO_CTRL) begin
			case (region)
				mvsPkg::REG_P1CNT[18:17]:    readWord = {dipSw, p1In[7:0]};
				mvsPkg::REG_P2CNT[18:17]:    readWord = {p2In[7:0], 8'hFF};
				// Upper player bits packed low, open bits high
				mvsPkg::REG_STATUS_B[18:17]: readWord = {12'hFFF, p2In[9:8], p1In[9:8]};
				default:                     readWord = mvsPkg::UNMAPPED_DATA;
			endcase
		end
	end

	// Output ports, LEDs, slot and system latches
	always_ff @(posedge clk24m) begin
		if (rst) begin
			p1Out    <= 3'd0;
			p2Out    <= 3'd0;
			ledOut1  <= 8'd0;
			ledOut2  <= 8'd0;
			slot     <= 3'd0;
			// Vectors come from BIOS after reset
			vecSwap  <= 1'b1;
			shadow   <= 1'b0;
			palBank  <= 1'b0;
			sramLock <= 1'b0;
			system   <= 1'b0;
		end else begin
			if (ctrlWr) begin
				case (reqAddr.ioView.group)
					mvsPkg::GRP_POUTPUT: begin
						p1Out <= reqDat[2:0];
						p2Out <= reqDat[5:3];
					end
					mvsPkg::GRP_LEDLATCH: begin
						// Bits 3 and 4 strobe each LED bank
						if (reqDat[3]) begin
							ledOut1 <= ledHold;
						end
						if (reqDat[4]) begin
							ledOut2 <= ledHold;
						end
					end
					mvsPkg::GRP_SLOT: slot <= reqDat[2:0];
					default: ;
				endcase
			end
			if (sysWr) begin
				case (reqAddr.ioView.index)
					mvsPkg::SYS_VEC:      vecSwap  <= sysVal;
					mvsPkg::SYS_SHADOW:   shadow   <= sysVal;
					mvsPkg::SYS_PALBANK:  palBank  <= sysVal;
					mvsPkg::SYS_SRAMLOCK: sramLock <= sysVal;
					mvsPkg::SYS_SYSTEM:   system   <= sysVal;
					// Indices 5..7 unused
					default: ;
				endcase
			end
		end
	end

	// LED holding register and read data
	always_ff @(posedge clk24m) begin
		if (ctrlWr && (reqAddr.ioView.group == mvsPkg::GRP_LEDDATA)) begin
			ledHold <= reqDat[7:0];
		end
		if (reqValid) begin
			regDat <= readWord;
		end
	end

	mvsCoinCtrl coinCtrl (
		.clk24m  (clk24m),
		.rst     (rst),
		.coinWr  (coinWr),
		.coinSel (coinSel),
		.coinVal (coinVal),
		.coinCnt (coinCnt),
		.lockout (lockout)
	);

endmodule

// File: mvsBusAck.sv
module mvsBusAck (
	input  logic        clk24m,
	input  logic        rst,
	input  logic        reqValid,
	input  logic        reqWe,
	input  logic [3:0]  reqZone,
	input  logic [15:0] regDat,
	input  logic [15:0] extDat,
	output logic        ack,
	output logic        done,
	output logic [15:0] datR
);

	logic        active;
	logic        ackQ;
	logic        fire;
	logic [2:0]  waitCnt;
	logic [2:0]  waitLoad;
	logic        weQ;
	logic [3:0]  zoneQ;
	logic [15:0] readSel;

	// Memory card is the only slow zone
	assign waitLoad = (reqZone == mvsPkg::ZONE_MEMCARD) ? mvsPkg::WAIT_MEMCARD
		: mvsPkg::WAIT_FAST;

	// Last wait cycle
	assign fire = active && (waitCnt == 3'd1);

	// Read data source by zone
	always_comb begin
		case (zoneQ)
			mvsPkg::ZONE_IO_CTRL,
			mvsPkg::ZONE_IO_SYS:   readSel = regDat;
			mvsPkg::ZONE_CART_ROM,
			mvsPkg::ZONE_BIOS_ROM,
			mvsPkg::ZONE_MEMCARD:  readSel = extDat;
			default:               readSel = mvsPkg::UNMAPPED_DATA;
		endcase
	end

	always_ff @(posedge clk24m) begin
		if (rst) begin
			active <= 1'b0;
			ackQ   <= 1'b0;
		end else begin
			ackQ <= fire;
			if (reqValid) begin
				active <= 1'b1;
			end else if (fire) begin
				active <= 1'b0;
			end
		end
	end

	// Wait counter, request copy and returned data
	always_ff @(posedge clk24m) begin
		if (reqValid) begin
			// reqValid cycle counts as the first wait
			waitCnt <= waitLoad - 3'd1;
			weQ     <= reqWe;
			zoneQ   <= reqZone;
		end else if (active) begin
			waitCnt <= waitCnt - 3'd1;
		end
		if (fire) begin
			datR <= weQ ? 16'd0 : readSel;
		end
	end

	// Bus ack and decoder release share one pulse
	assign ack  = ackQ;
	assign done = ackQ;

endmodule

// File: mvsSysIo.sv
module mvsSysIo (
	input  logic            clk24m,
	input  logic            rst,
	input  logic            cyc,
	input  logic            stb,
	input  logic            we,
	input  mvsPkg::mvsAddrT adr,
	input  logic [15:0]     datW,
	input  logic [1:0]      sel,
	output logic [15:0]     datR,
	output logic            ack,
	input  logic [15:0]     extDat,
	output logic            cartCs,
	output logic            biosCs,
	output logic            cardCs,
	input  logic [7:0]      dipSw,
	input  logic [9:0]      p1In,
	input  logic [9:0]      p2In,
	output logic [2:0]      p1Out,
	output logic [2:0]      p2Out,
	output logic [7:0]      ledOut1,
	output logic [7:0]      ledOut2,
	output logic [2:0]      slot,
	output logic            vecSwap,
	output logic            shadow,
	output logic            palBank,
	output logic            sramLock,
	output logic            system,
	output logic [1:0]      coinCnt,
	output logic [1:0]      lockout
);

	// Stage one to stages two and three
	logic            reqValid;
	logic            reqWe;
	mvsPkg::mvsAddrT reqAddr;
	logic [15:0]     reqDat;
	logic [3:0]      reqZone;
	// Stage two to three, and release back to one
	logic [15:0]     regDat;
	logic            done;

	mvsAddrDecode addrDecode (
		.clk24m (clk24m), .rst (rst),
		.cyc (cyc), .stb (stb), .we (we), .adr (adr), .datW (datW), .sel (sel),
		.vecSwap (vecSwap), .done (done),
		.reqValid (reqValid), .reqWe (reqWe), .reqAddr (reqAddr),
		.reqDat (reqDat), .reqZone (reqZone),
		.cartCs (cartCs), .biosCs (biosCs), .cardCs (cardCs)
	);

	mvsIoRegs ioRegs (
		.clk24m (clk24m), .rst (rst),
		.reqValid (reqValid), .reqWe (reqWe), .reqAddr (reqAddr),
		.reqDat (reqDat), .reqZone (reqZone),
		.dipSw (dipSw), .p1In (p1In), .p2In (p2In), .regDat (regDat),
		.p1Out (p1Out), .p2Out (p2Out), .ledOut1 (ledOut1), .ledOut2 (ledOut2),
		.slot (slot), .vecSwap (vecSwap), .shadow (shadow), .palBank (palBank),
		.sramLock (sramLock), .system (system),
		.coinCnt (coinCnt), .lockout (lockout)
	);

	mvsBusAck busAck (
		.clk24m (clk24m), .rst (rst),
		.reqValid (reqValid), .reqWe (reqWe), .reqZone (reqZone),
		.regDat (regDat), .extDat (extDat),
		.ack (ack), .done (done), .datR (datR)
	);

endmodule

// File: mvsSysIo_assert.sv
module mvsSysIo_assert (
	input logic clk24m,
	input logic rst,
	input logic stb,
	input logic ack,
	input logic cartCs,
	input logic biosCs,
	input logic cardCs
);
	timeunit 1ns;
	timeprecision 100ps;

	// Failures so far
	int assertFails = 0;

	// Single-cycle ack
	ackOneCycle: assert property (@(posedge clk24m) disable iff (rst) ack |=> !ack)
		else begin
			assertFails++;
			$error("ack high for two cycles in a row");
		end

	// Ack only inside a strobed transfer
	ackInStb: assert property (@(posedge clk24m) disable iff (rst) ack |-> stb)
		else begin
			assertFails++;
			$error("ack high while stb is low");
		end

	oneSelect: assert property (@(posedge clk24m) disable iff (rst)
		$onehot0({cartCs, biosCs, cardCs}))
		else begin
			assertFails++;
			$error("more than one chip select high");
		end

	// Selects clear once reset has been seen
	selectsAfterReset: assert property (@(posedge clk24m)
		rst |=> !(cartCs || biosCs || cardCs))
		else begin
			assertFails++;
			$error("chip select high in the cycle after reset");
		end

endmodule

bind mvsSysIo mvsSysIo_assert sysIoAssert (
	.clk24m (clk24m),
	.rst    (rst),
	.stb    (stb),
	.ack    (ack),
	.cartCs (cartCs),
	.biosCs (biosCs),
	.cardCs (cardCs)
);

// File: mvsSysIo_tb.sv
module mvsSysIo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_XFERS  = 400;
	localparam int PULSE      = int'(mvsPkg::COIN_PULSE_CYCLES);

	logic            clk24m;
	logic            rst;
	logic            cyc;
	logic            stb;
	logic            we;
	mvsPkg::mvsAddrT adr;
	logic [15:0]     datW;
	logic [1:0]      sel;
	logic [15:0]     datR;
	logic            ack;
	logic [15:0]     extDat;
	logic            cartCs;
	logic            biosCs;
	logic            cardCs;
	logic [7:0]      dipSw;
	logic [9:0]      p1In;
	logic [9:0]      p2In;
	logic [2:0]      p1Out;
	logic [2:0]      p2Out;
	logic [7:0]      ledOut1;
	logic [7:0]      ledOut2;
	logic [2:0]      slot;
	logic            vecSwap;
	logic            shadow;
	logic            palBank;
	logic            sramLock;
	logic            system;
	logic [1:0]      coinCnt;
	logic [1:0]      lockout;

	logic [15:0] lfsr = 16'd33481;
	int          mismatches = 0;
	int          failures = 0;

	// Reference model state starting from reset values
	logic        vecM = 1'b1;
	logic        shadowM = 1'b0;
	logic        palM = 1'b0;
	logic        sramM = 1'b0;
	logic        sysM = 1'b0;
	logic [2:0]  p1M = 3'd0;
	logic [2:0]  p2M = 3'd0;
	logic [2:0]  slotM = 3'd0;
	logic [7:0]  led1M = 8'd0;
	logic [7:0]  led2M = 8'd0;
	// LED holding register has no reset
	logic [7:0]  holdM = 8'hxx;
	logic [1:0]  lockM = 2'b00;
	// Edges since the last pulse start or PULSE when idle
	int          coinAge [2] = '{PULSE, PULSE};

	mvsSysIo DUT (.*);

	initial begin
		clk24m = 1'b0;
		forever #(CLK_PERIOD / 2) clk24m = ~clk24m;
	end

	// Whole run budget of ten cycles per transfer
	initial begin
		#(NUM_XFERS * 10 * CLK_PERIOD);
		$display("Watchdog expired, the transfer sequence did not finish in time");
		$display("Checks failed");
		$finish;
	end

	// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsrBit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrBit()};
		end
		return v;
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		mismatches++;
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
	endtask

	// Zone from the byte address map with the vector window first
	function automatic logic [3:0] zoneOf(input logic [22:0] word);
		logic [23:0] a;
		a = {word, 1'b0};
		if (vecM && word < 23'd64) begin
			return mvsPkg::ZONE_BIOS_ROM;
		end else if (a < 24'h100000) begin
			return mvsPkg::ZONE_CART_ROM;
		end else if (a >= 24'h300000 && a < 24'h3A0000) begin
			return mvsPkg::ZONE_IO_CTRL;
		end else if (a >= 24'h3A0000 && a < 24'h3B0000) begin
			return mvsPkg::ZONE_IO_SYS;
		end else if (a >= 24'h800000 && a < 24'h900000) begin
			return mvsPkg::ZONE_MEMCARD;
		end else if (a >= 24'hC00000 && a < 24'hD00000) begin
			return mvsPkg::ZONE_BIOS_ROM;
		end
		return mvsPkg::ZONE_NONE;
	endfunction

	function automatic logic [15:0] readModel(input logic [3:0] zone, input logic [23:0] a);
		case (zone)
			mvsPkg::ZONE_IO_CTRL: begin
				if (a < 24'h340000) begin
					return {dipSw, p1In[7:0]};
				end else if (a < 24'h380000) begin
					return {p2In[7:0], 8'hFF};
				end
				return {12'hFFF, p2In[9:8], p1In[9:8]};
			end
			mvsPkg::ZONE_CART_ROM, mvsPkg::ZONE_BIOS_ROM, mvsPkg::ZONE_MEMCARD: return extDat;
			// System latches are write only
			default: return 16'hFFFF;
		endcase
	endfunction

	task automatic applyWrite(input logic [3:0] zone, input logic [23:0] a,
			input logic [15:0] d);
		if (zone == mvsPkg::ZONE_IO_CTRL && a >= 24'h380000) begin
			case (a[6:4])
				mvsPkg::GRP_POUTPUT: begin
					p1M = d[2:0];
					p2M = d[5:3];
				end
				mvsPkg::GRP_LEDLATCH: begin
					led1M = d[3] ? holdM : led1M;
					led2M = d[4] ? holdM : led2M;
				end
				mvsPkg::GRP_SLOT:    slotM = d[2:0];
				mvsPkg::GRP_LEDDATA: holdM = d[7:0];
				mvsPkg::GRP_COIN: begin
					if (a[2]) begin
						lockM[a[1]] = d[0];
					end else if (d[0]) begin
						coinAge[a[1]] = 0;
					end
				end
				default: ;
			endcase
		end else if (zone == mvsPkg::ZONE_IO_SYS) begin
			case (a[3:1])
				3'd0: vecM = a[4];
				3'd1: shadowM = a[4];
				3'd2: palM = a[4];
				3'd3: sramM = a[4];
				3'd4: sysM = a[4];
				default: ;
			endcase
		end
	endtask

	task automatic risingEdge();
		@(posedge clk24m);
		for (int i = 0; i < 2; i++) begin
			if (coinAge[i] < PULSE) begin
				coinAge[i]++;
			end
		end
	endtask

	// Coin outputs checked every falling edge
	task automatic fallingEdge();
		@(negedge clk24m);
		if (coinCnt !== {coinAge[1] < PULSE, coinAge[0] < PULSE}) begin
			reportMismatch("coinCnt", coinCnt, {coinAge[1] < PULSE, coinAge[0] < PULSE});
		end
		if (lockout !== lockM) begin
			reportMismatch("lockout", lockout, lockM);
		end
	endtask

	task automatic checkSelects(input logic [3:0] zone);
		if (cartCs !== (zone == mvsPkg::ZONE_CART_ROM)) begin
			reportMismatch("cartCs", cartCs, zone == mvsPkg::ZONE_CART_ROM);
		end
		if (biosCs !== (zone == mvsPkg::ZONE_BIOS_ROM)) begin
			reportMismatch("biosCs", biosCs, zone == mvsPkg::ZONE_BIOS_ROM);
		end
		if (cardCs !== (zone == mvsPkg::ZONE_MEMCARD)) begin
			reportMismatch("cardCs", cardCs, zone == mvsPkg::ZONE_MEMCARD);
		end
	endtask

	task automatic checkOutputs();
		if (p1Out !== p1M) reportMismatch("p1Out", p1Out, p1M);
		if (p2Out !== p2M) reportMismatch("p2Out", p2Out, p2M);
		if (slot !== slotM) reportMismatch("slot", slot, slotM);
		if (ledOut1 !== led1M) reportMismatch("ledOut1", ledOut1, led1M);
		if (ledOut2 !== led2M) reportMismatch("ledOut2", ledOut2, led2M);
		if (vecSwap !== vecM) reportMismatch("vecSwap", vecSwap, vecM);
		if (shadow !== shadowM) reportMismatch("shadow", shadow, shadowM);
		if (palBank !== palM) reportMismatch("palBank", palBank, palM);
		if (sramLock !== sramM) reportMismatch("sramLock", sramLock, sramM);
		if (system !== sysM) reportMismatch("system", system, sysM);
	endtask

	// One bus transfer held until ack and then released
	task automatic doTransfer(input logic wr, input logic [22:0] word, input logic [15:0] data);
		logic [3:0]  zone;
		logic [23:0] a;
		logic [1:0]  selV;
		int          lat;
		int          expLat;
		logic        got;
		zone = zoneOf(word);
		a = {word, 1'b0};
		expLat = (zone == mvsPkg::ZONE_MEMCARD) ? 4 : 2;
		selV = 2'(randBits(2));
		risingEdge();
		cyc <= 1'b1;
		stb <= 1'b1;
		we <= wr;
		adr.word <= word;
		datW <= data;
		sel <= (selV == 2'b00) ? 2'b11 : selV;
		dipSw <= 8'(randBits(8));
		p1In <= 10'(randBits(10));
		p2In <= 10'(randBits(10));
		extDat <= 16'(randBits(16));
		fallingEdge();
		// Capture edge is cycle 0
		risingEdge();
		fallingEdge();
		checkSelects(mvsPkg::ZONE_NONE);
		lat = 0;
		got = 1'b0;
		while (!got && lat < 8) begin
			risingEdge();
			lat++;
			if (lat == 1 && wr) begin
				applyWrite(zone, a, data);
			end
			fallingEdge();
			checkSelects(zone);
			got = (ack === 1'b1);
		end
		if (!got) begin
			failures++;
			$display("No ack within 8 cycles for address %h at %0d ns", a, $time);
		end else begin
			if (lat != expLat) reportMismatch("ack latency", lat, expLat);
			if (!wr && datR !== readModel(zone, a)) begin
				reportMismatch("datR", datR, readModel(zone, a));
			end
		end
		checkOutputs();
		risingEdge();
		cyc <= 1'b0;
		stb <= 1'b0;
		fallingEdge();
		checkSelects(mvsPkg::ZONE_NONE);
		if (ack !== 1'b0) begin
			failures++;
			$display("ack stayed high past one cycle at %0d ns", $time);
		end
	endtask

	initial begin
		logic [2:0]  kind;
		logic        wr;
		logic [22:0] word;
		int          assertFails;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datW = 16'd0;
		sel = 2'b00;
		extDat = 16'd0;
		dipSw = 8'd0;
		p1In = 10'd0;
		p2In = 10'd0;
		repeat (16) @(posedge clk24m);
		rst <= 1'b0;
		fallingEdge();
		checkOutputs();
		checkSelects(mvsPkg::ZONE_NONE);
		if (ack !== 1'b0) reportMismatch("ack", ack, 1'b0);

		// Coin 1 pulse restarted by a rewrite before lockout 1 goes high
		doTransfer(1'b1, 23'h1C0030, 16'h0001);
		doTransfer(1'b1, 23'h1C0030, 16'h0001);
		doTransfer(1'b1, 23'h1C0032, 16'h0001);
		repeat (12) begin
			risingEdge();
			fallingEdge();
		end

		repeat (NUM_XFERS - 3) begin
			kind = 3'(randBits(3));
			wr = randBits(1);
			case (kind)
				// Vector window swapped while the latch is set
				3'd0: word = 23'(randBits(6));
				3'd1: word = {4'h0, 19'(randBits(19))};
				// 0x30, 0x34, 0x38 and open 0x3C
				3'd2: word = {4'h3, 2'(randBits(2)), 2'b00, 15'(randBits(15))};
				3'd3: begin
					// Write groups with the coin group favoured
					word = {4'h3, 4'h8, 9'd0, randBits(1) ? 3'd6 : 3'(randBits(3)), 3'(randBits(3))};
					wr = 1'b1;
				end
				3'd4: word = {4'h3, 4'hA, 11'd0, 1'(randBits(1)), 3'(randBits(3))};
				3'd5: word = {4'h8, 19'(randBits(19))};
				3'd6: word = {4'hC, 19'(randBits(19))};
				default: word = {3'b010, 1'(randBits(1)), 19'(randBits(19))};
			endcase
			doTransfer(wr, word, 16'(randBits(16)));
		end

		assertFails = DUT.sysIoAssert.assertFails;
		$display("Error counts: %0d mismatches, %0d protocol failures, %0d assertion failures",
			mismatches, failures, assertFails);
		if (mismatches + failures + assertFails == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// File: sources.f
mvsPkg.sv
mvsCoinCtrl.sv
mvsAddrDecode.sv
mvsIoRegs.sv
mvsBusAck.sv
mvsSysIo.sv
mvsSysIo_assert.sv
mvsSysIo_tb.sv
